// ==== build.f ====
+incdir+tb
source/cpuPkg.sv
source/regFile.sv
source/alu.sv
source/programCounter.sv
source/cpuFsm.sv
source/dualPortRam.sv
source/hostPort.sv
source/cpu.sv
tb/cpuTb.sv

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  cpuPkg::word_t a,
	input  cpuPkg::word_t b,
	input  cpuPkg::aluOp_t op,
	output cpuPkg::word_t result,
	output cpuPkg::flags_t flags
);

	// one extra bit for the carry out
	logic [cpuPkg::dataWidth:0] sum;
	logic [cpuPkg::dataWidth:0] diff;
	logic signA;
	logic signB;

	assign sum = {1'b0, a} + {1'b0, b};
	// a + ~b + 1, carry set means no borrow
	assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1;
	assign signA = a[cpuPkg::dataWidth-1];
	assign signB = b[cpuPkg::dataWidth-1];

	always_comb begin
		unique case (op)
			cpuPkg::aluAdd: begin
				result = sum[cpuPkg::dataWidth-1:0];
			end
			cpuPkg::aluSub: begin
				result = diff[cpuPkg::dataWidth-1:0];
			end
			cpuPkg::aluAnd: begin
				result = a & b;
			end
			cpuPkg::aluOr: begin
				result = a | b;
			end
			cpuPkg::aluXor: begin
				result = a ^ b;
			end
			cpuPkg::aluPassB: begin
				result = b;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	always_comb begin
		flags = '0;
		if (op == cpuPkg::aluAdd) begin
			flags.carry = sum[cpuPkg::dataWidth];
			// same-sign operands, result sign flipped
			flags.overflow = (signA == signB) &&
				(sum[cpuPkg::dataWidth-1] != signA);
		end else if (op == cpuPkg::aluSub) begin
			flags.carry = diff[cpuPkg::dataWidth];
			flags.overflow = (signA != signB) &&
				(diff[cpuPkg::dataWidth-1] != signA);
		end
		flags.low = a < b;
		flags.negative = $signed(a) < $signed(b);
		flags.zero = result == '0;
	end

endmodule

// ==== source/cpu.sv ====
`timescale 1ns/1ps

module cpu (
	input  logic Clk,
	input  logic arstN,
	input  logic run,
	input  logic hostReq,
	input  cpuPkg::hostCmd_t hostCmd,
	output logic hostAck,
	output cpuPkg::word_t hostRdata,
	output logic halted,
	output cpuPkg::word_t rdestOut
);

	cpuPkg::ctrl_t ctrl;
	cpuPkg::flags_t aluFlags;
	cpuPkg::word_t rsrcOut;
	cpuPkg::word_t aluB;
	cpuPkg::word_t aluResult;
	cpuPkg::word_t extImm;
	cpuPkg::word_t immLoad;
	cpuPkg::word_t load;
	cpuPkg::word_t ramQA;
	cpuPkg::word_t ramQB;
	cpuPkg::addr_t ramAddrA;
	cpuPkg::addr_t pc;
	cpuPkg::addr_t hostRamAddr;
	cpuPkg::word_t hostRamData;
	logic hostRamWe;
	logic pcClear;

	// sign or zero extension of imm8
	assign extImm = ctrl.signedImm ? {{8{ctrl.imm[7]}}, ctrl.imm} : {8'h00, ctrl.imm};
	// opLui puts the byte in the upper half
	assign immLoad = ctrl.immSel ? {ctrl.imm, 8'h00} : extImm;
	assign aluB = ctrl.immSel ? extImm : rsrcOut;
	assign ramAddrA = ctrl.ramAddrSel ? rsrcOut[cpuPkg::addrWidth-1:0] : pc;

	always_comb begin
		unique case (ctrl.loadSel)
			cpuPkg::loadRam: load = ramQA;
			cpuPkg::loadImm: load = immLoad;
			default: load = aluResult;
		endcase
	end

	regFile regFile_inst (.Clk(Clk), .arstN(arstN), .en(ctrl.regEn), .rdest(ctrl.rdest),
		.rsrc(ctrl.rsrc), .load(load), .rdestOut(rdestOut), .rsrcOut(rsrcOut));

	alu alu_inst (.a(rdestOut), .b(aluB), .op(ctrl.aluOp), .result(aluResult),
		.flags(aluFlags));

	programCounter programCounter_inst (.Clk(Clk), .arstN(arstN), .en(ctrl.pcEn),
		.clear(pcClear), .sel(ctrl.pcSel), .offset(extImm), .target(rsrcOut), .pc(pc));

	cpuFsm cpuFsm_inst (.Clk(Clk), .arstN(arstN), .run(run), .instr(ramQA),
		.aluFlags(aluFlags), .ctrl(ctrl), .pcClear(pcClear), .halted(halted));

	// port A belongs to the cpu, port B to the host
	dualPortRam dualPortRam_inst (.Clk(Clk), .addrA(ramAddrA), .dataA(rdestOut),
		.weA(ctrl.ramEn), .qA(ramQA), .addrB(hostRamAddr), .dataB(hostRamData),
		.weB(hostRamWe), .qB(ramQB));

	hostPort hostPort_inst (.Clk(Clk), .arstN(arstN), .req(hostReq), .cmd(hostCmd),
		.ack(hostAck), .rdata(hostRdata), .ramAddr(hostRamAddr), .ramData(hostRamData),
		.ramWe(hostRamWe), .ramQ(ramQB));

endmodule

// ==== source/cpuFsm.sv ====
`timescale 1ns/1ps

module cpuFsm (
	input  logic Clk,
	input  logic arstN,
	input  logic run,
	input  cpuPkg::word_t instr,
	input  cpuPkg::flags_t aluFlags,
	output cpuPkg::ctrl_t ctrl,
	output logic pcClear,
	output logic halted
);

	cpuPkg::cpuState_t state;
	cpuPkg::cpuState_t nextState;
	cpuPkg::word_t ir;
	cpuPkg::flags_t flagsQ;
	cpuPkg::opcode_t opcode;
	logic updatesFlags;

	assign opcode = cpuPkg::opcode_t'(ir[15:12]);
	assign updatesFlags = opcode inside {cpuPkg::opAdd, cpuPkg::opSub,
		cpuPkg::opAddi, cpuPkg::opCmp};

	always_comb begin
		nextState = state;
		unique case (state)
			cpuPkg::sIdle: begin
				if (run) begin
					nextState = cpuPkg::sFetch;
				end
			end
			cpuPkg::sFetch: nextState = cpuPkg::sDecode;
			cpuPkg::sDecode: nextState = cpuPkg::sExecute;
			cpuPkg::sExecute: begin
				if (opcode == cpuPkg::opLoad) begin
					nextState = cpuPkg::sMemRead;
				end else if (opcode == cpuPkg::opHalt) begin
					nextState = cpuPkg::sHalt;
				end else begin
					nextState = cpuPkg::sFetch;
				end
			end
			cpuPkg::sMemRead: nextState = cpuPkg::sWriteBack;
			cpuPkg::sWriteBack: nextState = cpuPkg::sFetch;
			cpuPkg::sHalt: begin
				if (!run) begin
					nextState = cpuPkg::sIdle;
				end
			end
			default: nextState = cpuPkg::sIdle;
		endcase
	end

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			state <= cpuPkg::sIdle;
			halted <= 1'b0;
			ir <= '0;
			flagsQ <= '0;
		end else begin
			state <= nextState;
			halted <= nextState == cpuPkg::sHalt;
			// ram output holds the fetched word during decode
			if (state == cpuPkg::sDecode) begin
				ir <= instr;
			end
			if (state == cpuPkg::sExecute && updatesFlags) begin
				flagsQ <= aluFlags;
			end
		end
	end

	// pc pinned at 0 while idle and on the way back from halt
	assign pcClear = (state == cpuPkg::sIdle) || (state == cpuPkg::sHalt && !run);

	always_comb begin
		ctrl = '0;
		ctrl.rdest = ir[11:8];
		ctrl.rsrc = ir[7:4];
		ctrl.imm = ir[7:0];
		ctrl.loadSel = cpuPkg::loadAlu;
		ctrl.pcSel = cpuPkg::pcInc;
		ctrl.aluOp = cpuPkg::aluAdd;
		unique case (state)
			cpuPkg::sExecute: begin
				ctrl.pcEn = opcode != cpuPkg::opHalt;
				unique case (opcode)
					cpuPkg::opAdd: ctrl.regEn = 1'b1;
					cpuPkg::opSub: begin
						ctrl.regEn = 1'b1;
						ctrl.aluOp = cpuPkg::aluSub;
					end
					cpuPkg::opAnd: begin
						ctrl.regEn = 1'b1;
						ctrl.aluOp = cpuPkg::aluAnd;
					end
					cpuPkg::opOr: begin
						ctrl.regEn = 1'b1;
						ctrl.aluOp = cpuPkg::aluOr;
					end
					cpuPkg::opXor: begin
						ctrl.regEn = 1'b1;
						ctrl.aluOp = cpuPkg::aluXor;
					end
					cpuPkg::opMov: begin
						ctrl.regEn = 1'b1;
						ctrl.aluOp = cpuPkg::aluPassB;
					end
					cpuPkg::opAddi: begin
						ctrl.regEn = 1'b1;
						ctrl.immSel = 1'b1;
						ctrl.signedImm = 1'b1;
					end
					cpuPkg::opMovi: begin
						ctrl.regEn = 1'b1;
						ctrl.loadSel = cpuPkg::loadImm;
					end
					cpuPkg::opLui: begin
						ctrl.regEn = 1'b1;
						ctrl.immSel = 1'b1;
						ctrl.loadSel = cpuPkg::loadImm;
					end
					cpuPkg::opLoad: ctrl.ramAddrSel = 1'b1;
					cpuPkg::opStor: begin
						ctrl.ramEn = 1'b1;
						ctrl.ramAddrSel = 1'b1;
					end
					cpuPkg::opCmp: ctrl.aluOp = cpuPkg::aluSub;
					cpuPkg::opBeq: begin
						ctrl.signedImm = 1'b1;
						ctrl.pcSel = flagsQ.zero ? cpuPkg::pcBranch : cpuPkg::pcInc;
					end
					cpuPkg::opBlt: begin
						ctrl.signedImm = 1'b1;
						ctrl.pcSel = flagsQ.negative ? cpuPkg::pcBranch : cpuPkg::pcInc;
					end
					cpuPkg::opJmp: ctrl.pcSel = cpuPkg::pcJump;
					default: ctrl.pcSel = cpuPkg::pcHold;
				endcase
			end
			// keep rsrc on the address so the loaded word stays on qA
			cpuPkg::sMemRead: ctrl.ramAddrSel = 1'b1;
			cpuPkg::sWriteBack: begin
				ctrl.ramAddrSel = 1'b1;
				ctrl.regEn = 1'b1;
				ctrl.loadSel = cpuPkg::loadRam;
			end
			default: ctrl.pcSel = cpuPkg::pcHold;
		endcase
	end

	noRegAndRamWrite: assert property (@(posedge Clk) disable iff (!arstN)
		!(ctrl.regEn && ctrl.ramEn));

	// halted only ever follows a decoded halt
	haltedAfterHaltOp: assert property (@(posedge Clk) disable iff (!arstN)
		halted |-> opcode == cpuPkg::opHalt);

endmodule

// ==== source/cpuPkg.sv ====
package cpuPkg;

	localparam int dataWidth = 16;
	localparam int addrWidth = 10;
	localparam int regCount = 16;

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [addrWidth-1:0] addr_t;
	typedef logic [$clog2(regCount)-1:0] regIdx_t;
	typedef logic [7:0] imm_t;

	// opcode in [15:12], rd in [11:8], rs in [7:4] or imm8 in [7:0]
	typedef enum logic [3:0] {
		opAdd, opSub, opAnd, opOr,
		opXor, opMov, opAddi, opMovi,
		opLui, opLoad, opStor, opCmp,
		opBeq, opBlt, opJmp, opHalt
	} opcode_t;

	typedef enum logic [2:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluPassB
	} aluOp_t;

	typedef struct packed {
		logic carry;
		// unsigned a < b
		logic low;
		logic overflow;
		logic zero;
		// signed a < b
		logic negative;
	} flags_t;

	typedef enum logic [2:0] {
		sIdle, sFetch, sDecode, sExecute, sMemRead, sWriteBack, sHalt
	} cpuState_t;

	typedef enum logic [1:0] {
		pcHold, pcInc, pcBranch, pcJump
	} pcSel_t;

	// register write source
	typedef enum logic [1:0] {
		loadAlu, loadRam, loadImm
	} loadSel_t;

	typedef struct packed {
		logic write;
		addr_t addr;
		word_t data;
	} hostCmd_t;

	typedef struct packed {
		logic regEn;
		logic ramEn;
		logic pcEn;
		// alu operand b from immediate; with loadImm, byte goes to upper half
		logic immSel;
		logic signedImm;
		// port A address from rsrc instead of pc
		logic ramAddrSel;
		loadSel_t loadSel;
		pcSel_t pcSel;
		aluOp_t aluOp;
		regIdx_t rdest;
		regIdx_t rsrc;
		imm_t imm;
	} ctrl_t;

endpackage

// ==== source/dualPortRam.sv ====
`timescale 1ns/1ps

module dualPortRam (
	input  logic Clk,
	input  cpuPkg::addr_t addrA,
	input  cpuPkg::word_t dataA,
	input  logic weA,
	output cpuPkg::word_t qA,
	input  cpuPkg::addr_t addrB,
	input  cpuPkg::word_t dataB,
	input  logic weB,
	output cpuPkg::word_t qB
);

	cpuPkg::word_t mem [2**cpuPkg::addrWidth];

	// read-before-write on each port, one cycle latency
	always_ff @(posedge Clk) begin
		if (weA) begin
			mem[addrA] <= dataA;
		end
		if (weB) begin
			mem[addrB] <= dataB;
		end
		qA <= mem[addrA];
		qB <= mem[addrB];
	end

	// cpu and host must never collide on one word
	noWriteCollision: assert property (@(posedge Clk)
		!(weA && weB && addrA == addrB));

endmodule

// ==== source/hostPort.sv ====
`timescale 1ns/1ps

module hostPort (
	input  logic Clk,
	input  logic arstN,
	input  logic req,
	input  cpuPkg::hostCmd_t cmd,
	output logic ack,
	output cpuPkg::word_t rdata,
	output cpuPkg::addr_t ramAddr,
	output cpuPkg::word_t ramData,
	output logic ramWe,
	input  cpuPkg::word_t ramQ
);

	typedef enum logic [1:0] {idle, access, acked} hostState_t;

	hostState_t state;

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
		end else begin
			unique case (state)
				idle: begin
					if (req) begin
						state <= access;
					end
				end
				access: state <= acked;
				acked: begin
					if (!req) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// cmd is stable before req, so ramQ already holds the word in access
	always_ff @(posedge Clk) begin
		if (state == access) begin
			rdata <= ramQ;
		end
	end

	assign ramAddr = cmd.addr;
	assign ramData = cmd.data;
	assign ramWe = (state == access) && cmd.write;
	assign ack = state == acked;

	ackNeedsReq: assert property (@(posedge Clk) disable iff (!arstN)
		$rose(ack) |-> $past(req));

endmodule

// ==== source/programCounter.sv ====
`timescale 1ns/1ps

module programCounter (
	input  logic Clk,
	input  logic arstN,
	input  logic en,
	input  logic clear,
	input  cpuPkg::pcSel_t sel,
	input  cpuPkg::word_t offset,
	input  cpuPkg::word_t target,
	output cpuPkg::addr_t pc
);

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (clear) begin
			pc <= '0;
		end else if (en) begin
			unique case (sel)
				cpuPkg::pcInc: begin
					pc <= pc + 1'b1;
				end
				// offset is relative to this instruction, wraps mod memory size
				cpuPkg::pcBranch: begin
					pc <= pc + offset[cpuPkg::addrWidth-1:0];
				end
				cpuPkg::pcJump: begin
					pc <= target[cpuPkg::addrWidth-1:0];
				end
				default: begin
					pc <= pc;
				end
			endcase
		end
	end

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input  logic Clk,
	input  logic arstN,
	input  logic en,
	input  cpuPkg::regIdx_t rdest,
	input  cpuPkg::regIdx_t rsrc,
	input  cpuPkg::word_t load,
	output cpuPkg::word_t rdestOut,
	output cpuPkg::word_t rsrcOut
);

	cpuPkg::word_t regs [cpuPkg::regCount];

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < cpuPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (en) begin
			regs[rdest] <= load;
		end
	end

	// both reads combinational
	assign rdestOut = regs[rdest];
	assign rsrcOut = regs[rsrc];

	// an X on the enable would smear a register silently
	enKnown: assert property (@(posedge Clk) disable iff (!arstN)
		!$isunknown(en));

endmodule

// ==== tb/cpuTbPrograms.svh ====
`ifndef CPU_TB_PROGRAMS_SVH
`define CPU_TB_PROGRAMS_SVH

// encoding is op[15:12] rd[11:8] rs[7:4], or op[15:12] rd[11:8] imm8[7:0]
// movi 7, addi 6, lui 8, add 0, sub 1, and 2, or 3, xor 4, mov 5
// load 9, stor a, cmp b, beq c, blt d, jmp e, halt f
// rd field of the halt picks the register left on rdestOut
typedef struct packed {
	logic [63:0] name;
	logic [0:15][15:0] code;
	cpuPkg::addr_t preAddr;
	cpuPkg::word_t preData;
	cpuPkg::addr_t resAddr;
	cpuPkg::word_t expected;
	cpuPkg::word_t expectedReg;
} progEntry_t;

localparam int numPrograms = 7;

// field order: name, 16 code words from address 0, preload address and word,
// result address, expected word, expected register at halt
function automatic progEntry_t programAt(input int idx);
	progEntry_t e;
	case (idx)
		// 0xff00 + 0xf0 + 0x25 wraps to 0x15, then 0x40 - 0x15 = 0x2b
		0: e = {"regArith",
			16'h71f0, 16'h82ff, 16'h0210, 16'h7325, 16'h0230, 16'h7440,
			16'h1420, 16'h7580, 16'ha450, 16'hf200, {6{16'h0000}},
			10'h080, 16'hdead, 10'h080, 16'h002b, 16'h0015};
		// mov 0xca, and 0x5f gives 0x4a, xor with (0xca | 0x5f) gives 0x95
		1: e = {"regLogic",
			16'h71ca, 16'h725f, 16'h5310, 16'h2320, 16'h3120, 16'h4310,
			16'h7681, 16'ha360, 16'hf100, {7{16'h0000}},
			10'h081, 16'hdead, 10'h081, 16'h0095, 16'h00df};
		// 0xf3 - 2 = 0xf1, lui/addi build 0x1234, sum is 0x1325
		2: e = {"immedExt",
			16'h71f3, 16'h61fe, 16'h8212, 16'h6234, 16'h0210, 16'h7782,
			16'ha270, 16'hf100, {8{16'h0000}},
			10'h082, 16'hdead, 10'h082, 16'h1325, 16'h00f1};
		// loop at 4 adds i to sum while i < 6, blt at 7 jumps back by 3
		3: e = {"loopSum5",
			16'h7100, 16'h7201, 16'h7306, 16'h7483, 16'h0120, 16'h6201,
			16'hb230, 16'hd0fd, 16'ha140, 16'hf200, {6{16'h0000}},
			10'h083, 16'hdead, 10'h083, 16'h000f, 16'h0006};
		// load 0xbeef from 0x100, beq at 5 skips two addi, 0xbeef + 0x10
		4: e = {"branchEq",
			16'h8101, 16'h9210, 16'h7305, 16'h7405, 16'hb340, 16'hc003,
			16'h6201, 16'h6201, 16'h6210, 16'h7584, 16'ha250, 16'hf100,
			{4{16'h0000}},
			10'h100, 16'hbeef, 10'h084, 16'hbeff, 16'h0100};
		// jmp r3 to the halt at 5, the store of 0x77 never runs
		5: e = {"jumpSkip",
			16'h7185, 16'h7277, 16'h7305, 16'he030, 16'ha210, 16'hf200,
			{10{16'h0000}},
			10'h085, 16'h5a5a, 10'h085, 16'h5a5a, 16'h0077};
		// short program, only correct if the pc starts over at 0
		6: e = {"restart0",
			16'h7186, 16'h723c, 16'ha210, 16'hf100, {12{16'h0000}},
			10'h086, 16'hdead, 10'h086, 16'h003c, 16'h0086};
		default: e = '0;
	endcase
	return e;
endfunction

`endif

// ==== tb/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

	localparam int clkPeriod = 100;

	`include "cpuTbPrograms.svh"

	logic Clk;
	logic arstN;
	logic run;
	logic hostReq;
	cpuPkg::hostCmd_t hostCmd;
	logic hostAck;
	cpuPkg::word_t hostRdata;
	logic halted;
	cpuPkg::word_t rdestOut;

	integer seed = 32'h6f07;
	int errorCount = 0;
	int checkCount = 0;

	cpu cpu_inst (.Clk(Clk), .arstN(arstN), .run(run), .hostReq(hostReq),
		.hostCmd(hostCmd), .hostAck(hostAck), .hostRdata(hostRdata), .halted(halted),
		.rdestOut(rdestOut));

	initial begin
		Clk = 1'b0;
		forever #(clkPeriod / 2) Clk = ~Clk;
	end

	// budget of 300 cycles per program
	initial begin
		#(numPrograms * 300 * clkPeriod);
		$display("watchdog expired before all tests finished");
		$display("Verification failed");
		$finish;
	end

	task automatic checkWord(input logic [63:0] name, input cpuPkg::word_t expected,
			input cpuPkg::word_t actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Fail %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// one four-phase req/ack cycle, called and returning on a falling edge
	task automatic hostTransfer(input logic isWrite, input cpuPkg::addr_t addr,
			input cpuPkg::word_t data, output cpuPkg::word_t rdata);
		hostCmd.write = isWrite;
		hostCmd.addr = addr;
		hostCmd.data = data;
		hostReq = 1'b1;
		while (hostAck !== 1'b1) @(negedge Clk);
		rdata = hostRdata;
		hostReq = 1'b0;
		while (hostAck !== 1'b0) @(negedge Clk);
	endtask

	// start from address 0, wait for halt, then return the FSM to idle
	task automatic runProgram(output cpuPkg::word_t haltReg);
		run = 1'b1;
		while (halted !== 1'b1) @(negedge Clk);
		// register named by the halt word
		haltReg = rdestOut;
		run = 1'b0;
		while (halted !== 1'b0) @(negedge Clk);
	endtask

	initial begin
		cpuPkg::word_t rdata;
		cpuPkg::word_t haltReg;
		cpuPkg::addr_t addrs [8];
		cpuPkg::word_t words [8];
		logic [31:0] rnd;
		progEntry_t entry;

		arstN = 1'b0;
		run = 1'b0;
		hostReq = 1'b0;
		hostCmd = '0;
		repeat (5) @(posedge Clk);
		@(negedge Clk);
		arstN = 1'b1;
		checkWord("resetAck", '0, cpuPkg::word_t'(hostAck));
		checkWord("resetHlt", '0, cpuPkg::word_t'(halted));

		// one address per 128-word slot so no two writes land on one word
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			addrs[i] = {i[2:0], rnd[6:0]};
			words[i] = rnd[31:16];
			hostTransfer(1'b1, addrs[i], words[i], rdata);
		end
		for (int i = 0; i < 8; i++) begin
			hostTransfer(1'b0, addrs[i], '0, rdata);
			checkWord("hostData", words[i], rdata);
		end

		for (int p = 0; p < numPrograms; p++) begin
			entry = programAt(p);
			for (int w = 0; w < 16; w++) begin
				hostTransfer(1'b1, cpuPkg::addr_t'(w), entry.code[w], rdata);
			end
			hostTransfer(1'b1, entry.preAddr, entry.preData, rdata);
			runProgram(haltReg);
			checkWord(entry.name, entry.expectedReg, haltReg);
			hostTransfer(1'b0, entry.resAddr, '0, rdata);
			checkWord(entry.name, entry.expected, rdata);
		end

		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
